// ==== include/pref_defs.svh ====
`ifndef PREF_DEFS_SVH
`define PREF_DEFS_SVH

// Default parameter values for the prefetch subsystem
`define DEF_ADDR_WIDTH   32
`define DEF_INDEX_BITS   3

// Cycles from miss acceptance to completion
`define DEF_FILL_LATENCY 4

`endif

// ==== hw/pref_pkg.sv ====
`default_nettype none

package pref_pkg;

    // 32-byte lines, eight sets
    localparam int LINE_OFFSET_BITS = 5;
    localparam int PKG_INDEX_BITS   = 3;
    localparam int PKG_TAG_BITS     = 32 - LINE_OFFSET_BITS - PKG_INDEX_BITS;

    // Address register contents while no request is pending
    localparam logic [31:0] IDLE_ADDR = 32'h1234_ABCD;

    // Prefetch addresses live in the low 16 MB
    localparam logic [31:0] PREF_ADDR_MASK = 32'h00FF_FFFF;

    typedef enum logic {
        PREF_INSTR = 1'b0,
        PREF_DATA  = 1'b1
    } pref_type_e;

    // Generator writes raw, cache reads the fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [PKG_TAG_BITS-1:0]     tag;
            logic [PKG_INDEX_BITS-1:0]   index;
            logic [LINE_OFFSET_BITS-1:0] offset;
        } f;
    } pref_addr_u;

endpackage

`default_nettype wire

// ==== hw/pref_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pref_if import pref_pkg::*; (
    input wire logic clk
);

    logic       req;
    pref_type_e ptype;
    pref_addr_u addr;
    logic       complete;
    // Only meaningful in the complete cycle
    logic       hit;

    modport gen (
        input  clk,
        input  complete,
        input  hit,
        output req,
        output ptype,
        output addr
    );

    modport cache (
        input  clk,
        input  req,
        input  ptype,
        input  addr,
        output complete,
        output hit
    );

endinterface

`default_nettype wire

// ==== hw/lfsr_random.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_random (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        en,
    output logic      [31:0] randnum
);

    localparam logic [31:0] SEED = 32'h0000_0001;
    // Taps 32, 22, 2, 1 in right-shift Galois form
    localparam logic [31:0] TAPS = 32'h8020_0003;

    logic [31:0] lfsr_q;
    logic [31:0] lfsr_nxt;

    assign lfsr_nxt = lfsr_q[0] ? ((lfsr_q >> 1) ^ TAPS) : (lfsr_q >> 1);

    // Consumer sees the value the register steps to on this strobe
    assign randnum = lfsr_nxt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lfsr_q <= SEED;
        end else if (en) begin
            lfsr_q <= lfsr_nxt;
        end
    end

    // All-zero state would lock the sequence up
    a_lfsr_nonzero: assert property (
        @(posedge clk) disable iff (!rstn)
        lfsr_q != '0
    ) else $error("LFSR reached the all-zero state");

endmodule

`default_nettype wire

// ==== hw/pref_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pref_gen import pref_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        pref_en,
    input  wire logic [31:0] randnum,
    output logic             rand_en,
    pref_if.gen              bus
);

    localparam logic S_IDLE = 1'b0;
    localparam logic S_REQ  = 1'b1;

    localparam logic [3:0] GAP_MIN = 4'd1;
    localparam logic [3:0] GAP_MAX = 4'd9;

    logic       state;
    logic       state_nxt;
    logic [3:0] gap;
    logic [3:0] gap_cnt;
    logic       launch;
    logic       type_bit;
    pref_addr_u addr_q;
    pref_type_e ptype_q;

    // Fires once the idle count reaches the current gap
    assign launch  = (state == S_IDLE) && pref_en && (gap_cnt == gap);
    assign rand_en = launch;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (launch) begin
                    state_nxt = S_REQ;
                end
            end
            S_REQ: begin
                if (bus.complete) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Gap grows 1..9 and wraps; counter frozen during a request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            gap     <= GAP_MIN;
            gap_cnt <= '0;
        end else if (launch) begin
            gap     <= (gap == GAP_MAX) ? GAP_MIN : gap + 4'd1;
            gap_cnt <= '0;
        end else if (state == S_IDLE && pref_en) begin
            gap_cnt <= gap_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            type_bit <= 1'b0;
        end else begin
            type_bit <= ~type_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            addr_q.raw <= IDLE_ADDR;
        end else if (launch) begin
            addr_q.raw <= randnum & PREF_ADDR_MASK;
        end else if (state == S_REQ && bus.complete) begin
            addr_q.raw <= IDLE_ADDR;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            ptype_q <= pref_type_e'(type_bit);
        end
    end

    assign bus.req   = (state == S_REQ);
    assign bus.addr  = addr_q;
    assign bus.ptype = ptype_q;

    // Request payload must not move until the cache answers
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        bus.req && !bus.complete |=> bus.req && $stable(addr_q) && $stable(ptype_q)
    ) else $error("Prefetch request changed before completion");

    a_no_stray_complete: assert property (
        @(posedge clk) disable iff (!rstn)
        state == S_IDLE |-> !bus.complete
    ) else $error("Completion seen with no request outstanding");

endmodule

`default_nettype wire

// ==== hw/l2_pref_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_pref_cache import pref_pkg::*; #(
    parameter int INDEX_BITS   = 3,
    parameter int FILL_LATENCY = 4
) (
    input  wire logic clk,
    input  wire logic rstn,
    pref_if.cache     bus
);

    localparam int SETS     = 1 << INDEX_BITS;
    localparam int TAG_BITS = PKG_TAG_BITS;
    localparam int CW       = (FILL_LATENCY > 1) ? $clog2(FILL_LATENCY + 1) : 1;

    logic [TAG_BITS-1:0]   tag_mem [SETS];
    logic [SETS-1:0]       valid_i;
    logic [SETS-1:0]       valid_d;

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   req_tag;
    logic                  is_data;
    logic                  type_valid;
    logic                  tag_match;
    logic                  lookup_hit;

    logic                  busy;
    logic [CW-1:0]         fill_cnt;
    logic                  hit_q;
    logic                  done_now;

    // Address fields are stable for the whole request
    assign idx     = INDEX_BITS'(bus.addr.f.index);
    assign req_tag = bus.addr.f.tag;
    assign is_data = (bus.ptype == PREF_DATA);

    assign tag_match  = (tag_mem[idx] == req_tag);
    assign type_valid = is_data ? valid_d[idx] : valid_i[idx];
    assign lookup_hit = tag_match && type_valid;

    // Hit loads 1, miss loads the fill delay; complete when it reaches 1
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            fill_cnt <= '0;
        end else if (!busy) begin
            if (bus.req) begin
                busy     <= 1'b1;
                fill_cnt <= lookup_hit ? CW'(1) : CW'(FILL_LATENCY);
            end
        end else if (done_now) begin
            busy <= 1'b0;
        end else begin
            fill_cnt <= fill_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && bus.req) begin
            hit_q <= lookup_hit;
        end
    end

    assign done_now     = busy && (fill_cnt == CW'(1));
    assign bus.complete = done_now;
    assign bus.hit      = done_now && hit_q;

    // Line allocation happens in the completing cycle of a miss
    always_ff @(posedge clk) begin
        if (done_now && !hit_q) begin
            tag_mem[idx] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_i <= '0;
            valid_d <= '0;
        end else if (done_now && !hit_q) begin
            if (is_data) begin
                valid_d[idx] <= 1'b1;
                if (!tag_match) begin
                    valid_i[idx] <= 1'b0;
                end
            end else begin
                valid_i[idx] <= 1'b1;
                if (!tag_match) begin
                    valid_d[idx] <= 1'b0;
                end
            end
        end
    end

    a_index_width: assert property (
        @(posedge clk) INDEX_BITS == PKG_INDEX_BITS
    ) else $error("INDEX_BITS does not match the address union layout");

    a_complete_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        bus.complete |=> !bus.complete
    ) else $error("Completion held for more than one cycle");

    a_complete_with_req: assert property (
        @(posedge clk) disable iff (!rstn)
        bus.complete |-> bus.req
    ) else $error("Completion without a pending request");

endmodule

`default_nettype wire

// ==== hw/pref_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pref_defs.svh"

module pref_top #(
    parameter int ADDR_WIDTH   = `DEF_ADDR_WIDTH,
    parameter int INDEX_BITS   = `DEF_INDEX_BITS,
    parameter int FILL_LATENCY = `DEF_FILL_LATENCY
) (
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  pref_en,
    output logic                       done,
    output logic      [ADDR_WIDTH-1:0] done_addr,
    output logic                       done_type,
    output logic                       done_hit
);

    logic        rand_en;
    logic [31:0] randnum;

    pref_if bus (
        .clk (clk)
    );

    lfsr_random u_lfsr (
        .clk     (clk),
        .rstn    (rstn),
        .en      (rand_en),
        .randnum (randnum)
    );

    pref_gen u_gen (
        .clk     (clk),
        .rstn    (rstn),
        .pref_en (pref_en),
        .randnum (randnum),
        .rand_en (rand_en),
        .bus     (bus.gen)
    );

    l2_pref_cache #(
        .INDEX_BITS   (INDEX_BITS),
        .FILL_LATENCY (FILL_LATENCY)
    ) u_cache (
        .clk  (clk),
        .rstn (rstn),
        .bus  (bus.cache)
    );

    // Result strobe mirrors the completion cycle directly
    assign done      = bus.complete;
    assign done_addr = bus.addr.raw[ADDR_WIDTH-1:0];
    assign done_type = bus.ptype;
    assign done_hit  = bus.hit;

endmodule

`default_nettype wire

// ==== tb/tb_pref_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pref_defs.svh"

module tb_pref_top;

    localparam int          FILL_LATENCY = `DEF_FILL_LATENCY;
    localparam int          IDX_W        = `DEF_INDEX_BITS;
    localparam int          OFF_W        = 5;
    localparam int          TAG_W        = 32 - IDX_W - OFF_W;
    localparam int          SETS         = 1 << IDX_W;
    localparam int          NUM_REQ      = 200;
    localparam int          TIMEOUT      = 200;
    localparam int          RESET_CYCLES = 3;
    localparam logic [31:0] SEED         = 32'ha04d012b;

    logic        clk;
    logic        rstn;
    logic        pref_en;
    logic        done;
    logic [31:0] done_addr;
    logic        done_type;
    logic        done_hit;

    int errors = 0;

    // Expected cache contents, one entry per set
    bit [TAG_W-1:0] model_tag [SETS];
    bit             model_vi  [SETS];
    bit             model_vd  [SETS];

    pref_top #(
        .ADDR_WIDTH   (`DEF_ADDR_WIDTH),
        .INDEX_BITS   (`DEF_INDEX_BITS),
        .FILL_LATENCY (`DEF_FILL_LATENCY)
    ) UUT (
        .clk       (clk),
        .rstn      (rstn),
        .pref_en   (pref_en),
        .done      (done),
        .done_addr (done_addr),
        .done_type (done_type),
        .done_hit  (done_hit)
    );

    always #10 clk = ~clk;

    // Galois form, taps 32 22 2 1
    // Tap n flips bit n-1 when the bit shifted out is set
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] nxt;
        nxt = s >> 1;
        if (s[0]) begin
            nxt[31] = ~nxt[31];
            nxt[21] = ~nxt[21];
            nxt[1]  = ~nxt[1];
            nxt[0]  = ~nxt[0];
        end
        return nxt;
    endfunction

    function automatic logic [31:0] mask_addr(input logic [31:0] v);
        return {8'h00, v[23:0]};
    endfunction

    // Returns the expected hit flag and allocates the line on a miss
    function automatic bit predict_hit(input logic [31:0] addr, input bit is_data);
        int         idx;
        bit [TAG_W-1:0] tag;
        bit         same_tag;
        bit         hit;
        idx      = addr[OFF_W +: IDX_W];
        tag      = addr[31 -: TAG_W];
        same_tag = (model_tag[idx] == tag);
        hit      = same_tag && (is_data ? model_vd[idx] : model_vi[idx]);
        if (!hit) begin
            model_tag[idx] = tag;
            if (is_data) begin
                model_vd[idx] = 1'b1;
                if (!same_tag) begin
                    model_vi[idx] = 1'b0;
                end
            end else begin
                model_vi[idx] = 1'b1;
                if (!same_tag) begin
                    model_vd[idx] = 1'b0;
                end
            end
        end
        return hit;
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    initial begin : stimulus
        int unsigned seed_init;
        clk       = 1'b0;
        rstn      = 1'b0;
        pref_en   = 1'b0;
        seed_init = $urandom(SEED);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        // Quiet period so the first request waits on pref_en
        repeat (6) @(negedge clk);
        forever begin
            @(negedge clk);
            pref_en = ($urandom % 6) != 0;
        end
    end

    // Samples mid-cycle, values are those the next rising edge sees
    initial begin : compare_proc
        int          n;
        int          waited;
        int          cyc;
        int          gap_m;
        int          cnt_m;
        int          exp_done;
        int          hits;
        bit          launched;
        bit          got_done;
        bit          exp_type;
        bit          exp_hit;
        logic [31:0] lfsr_m;
        logic [31:0] exp_addr;
        lfsr_m = 32'h1;
        gap_m  = 1;
        cnt_m  = 0;
        cyc    = 0;
        hits   = 0;
        waited = 0;
        while (rstn !== 1'b1) begin
            if (waited == TIMEOUT) begin
                $display("Reset was never released by the stimulus");
                $display("** FAIL **");
                $fatal(1, "Timeout");
            end
            @(negedge clk);
            #1;
            waited++;
        end
        for (n = 0; n < NUM_REQ; n++) begin
            launched = 1'b0;
            got_done = 1'b0;
            waited   = 0;
            while (!got_done) begin
                if (waited == TIMEOUT) begin
                    $display("No done pulse for request %0d within %0d cycles", n, TIMEOUT);
                    $display("** FAIL **");
                    $fatal(1, "Timeout");
                end
                if (!launched) begin
                    check_eq(done, 1'b0, "done while no request is pending");
                    if (pref_en) begin
                        if (cnt_m == gap_m) begin
                            lfsr_m   = lfsr_step(lfsr_m);
                            exp_addr = mask_addr(lfsr_m);
                            exp_type = cyc[0];
                            exp_hit  = predict_hit(exp_addr, exp_type);
                            exp_done = cyc + 1 + (exp_hit ? 1 : FILL_LATENCY);
                            gap_m    = (gap_m == 9) ? 1 : gap_m + 1;
                            cnt_m    = 0;
                            launched = 1'b1;
                        end else begin
                            cnt_m++;
                        end
                    end
                end else if (done || cyc == exp_done) begin
                    check_eq(done, 1'b1, "done pulse missing");
                    check_eq(cyc, exp_done, "done cycle");
                    check_eq(done_addr[31:24], 8'h00, "done_addr upper byte");
                    check_eq(done_addr, exp_addr, "done_addr");
                    check_eq(done_type, exp_type, "done_type");
                    check_eq(done_hit, exp_hit, "done_hit");
                    hits     = hits + (exp_hit ? 1 : 0);
                    got_done = 1'b1;
                end
                waited++;
                cyc++;
                @(negedge clk);
                #1;
            end
        end
        $display("%0d requests checked, %0d hits", NUM_REQ, hits);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
hw/pref_pkg.sv
hw/pref_if.sv
hw/lfsr_random.sv
hw/pref_gen.sv
hw/l2_pref_cache.sv
hw/pref_top.sv
tb/tb_pref_top.sv

// ==== Bender.yml ====
package:
  name: pref_top

export_include_dirs:
  - include

sources:
  - hw/pref_pkg.sv
  - hw/pref_if.sv
  - hw/lfsr_random.sv
  - hw/pref_gen.sv
  - hw/l2_pref_cache.sv
  - hw/pref_top.sv
  - target: test
    files:
      - tb/tb_pref_top.sv
